// ==== all.f ====
common/merge_gen_pkg.sv
generator/generator_fsm.sv
generator/index_counter.sv
generator/request_builder.sv
src/request_fifo.sv
src/merge_data_generator.sv
verification/tb_merge_data_generator.sv

// ==== verification/tb_merge_data_generator.sv ====
// Testbench for the index request generator: reference model, stimulus and request checker
`timescale 1ns/1ns
`default_nettype none

module tb_merge_data_generator
    import merge_gen_pkg::*;
();

    logic         ap_clk;
    logic         areset_generator;
    logic         config_valid;
    logic         config_ready;
    gen_config_t  gen_config;
    logic         request_valid;
    logic         request_ready;
    mem_request_t request;
    logic         done;

    // Run currently being checked
    gen_config_t  cur_cfg;
    int           expected_total;
    int           received;
    mem_request_t exp_req;
    int           unused_total;

    // Ready driver controls
    int           hold_left    = 0;
    logic         random_ready = 1'b0;

    int           seed_value;
    gen_config_t  cfg;

    merge_data_generator DUT (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .config_valid     (config_valid),
        .config_ready     (config_ready),
        .gen_config       (gen_config),
        .request_valid    (request_valid),
        .request_ready    (request_ready),
        .request          (request),
        .done             (done)
    );

    initial begin
        ap_clk = 1'b0;
    end

    always #5 ap_clk = ~ap_clk;

    // ------------------------------------------------------------------------
    // Reference model and helpers
    // ------------------------------------------------------------------------
    // Request number k of a run, plus the length of the whole run
    function automatic mem_request_t reference_request(input gen_config_t c, input int k,
                                                       output int total);
        int                idx;
        index_t            data_idx;
        logic [ADDR_W-1:0] index_ext;
        mem_request_t      req;
        total = 0;
        idx   = c.index_start;
        while (idx < c.index_end) begin
            total = total + 1;
            idx   = idx + c.stride;
        end
        data_idx  = c.index_start + k * c.stride;
        index_ext = '0;
        index_ext[INDEX_W-1:0] = data_idx;
        req.base = c.array_pointer;
        if (c.shift_left) begin
            req.offset = index_ext << c.shift_amount;
        end else begin
            req.offset = index_ext >> c.shift_amount;
        end
        req.data = data_idx;
        return req;
    endfunction

    task automatic check_value(input string name, input logic [79:0] actual,
                               input logic [79:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "Stopping on first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "Stopping on timeout");
    endtask

    // Takes effect from the next falling edge
    task automatic set_ready_mode(input int hold, input logic rnd);
        @(posedge ap_clk);
        hold_left    = hold;
        random_ready = rnd;
        @(negedge ap_clk);
    endtask

    // Called on a falling edge; returns on the falling edge after the transfer
    task automatic send_config(input gen_config_t c);
        int cycles;
        cur_cfg = c;
        void'(reference_request(c, 0, expected_total));
        received     = 0;
        gen_config   = c;
        config_valid = 1'b1;
        cycles       = 0;
        while (!config_ready) begin
            if (cycles >= 200) begin
                report_timeout("config_ready stayed low");
            end
            @(negedge ap_clk);
            cycles++;
        end
        @(negedge ap_clk);
        config_valid = 1'b0;
        // The accepting edge leaves DONE and starts a new run
        check_value("done", done, 0);
        check_value("config_ready", config_ready, 0);
    endtask

    task automatic wait_for_done(input int limit);
        int cycles;
        cycles = 0;
        while (!done) begin
            if (cycles >= limit) begin
                report_timeout("done did not rise");
            end
            @(negedge ap_clk);
            cycles++;
        end
        // All requests must be through before done
        check_value("received", received, expected_total);
        check_value("request_valid", request_valid, 0);
    endtask

    task automatic run_config(input gen_config_t c, input int limit);
        send_config(c);
        wait_for_done(limit);
    endtask

    function automatic gen_config_t random_config();
        gen_config_t c;
        c               = '0;
        c.array_pointer = $urandom;
        c.index_start   = $urandom % 50;
        c.index_end     = c.index_start + ($urandom % 60) + 1;
        c.stride        = 1 + ($urandom % 7);
        c.shift_amount  = $urandom % 32;
        c.shift_left    = 1'b0;
        return c;
    endfunction

    // ------------------------------------------------------------------------
    // Request ready driver
    // ------------------------------------------------------------------------
    always @(negedge ap_clk) begin
        if (hold_left > 0) begin
            request_ready = 1'b0;
            hold_left     = hold_left - 1;
        end else if (random_ready) begin
            request_ready = ($urandom % 2) != 0;
        end else begin
            request_ready = 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Request checker
    // ------------------------------------------------------------------------
    always @(posedge ap_clk) begin
        if (!areset_generator && request_valid && request_ready) begin
            if (received >= expected_total) begin
                $display("Request arrived beyond the expected count of %0d", expected_total);
                $display("SIMULATION FAILED");
                $fatal(1, "Stopping on extra request");
            end else begin
                exp_req = reference_request(cur_cfg, received, unused_total);
                check_value("request.base", request.base, exp_req.base);
                check_value("request.offset", request.offset, exp_req.offset);
                check_value("request.data", request.data, exp_req.data);
                received = received + 1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        seed_value       = $urandom(77657);
        areset_generator = 1'b1;
        config_valid     = 1'b0;
        gen_config       = '0;
        request_ready    = 1'b1;
        cur_cfg          = '0;
        expected_total   = 0;
        received         = 0;

        repeat (16) @(negedge ap_clk);
        areset_generator = 1'b0;
        @(negedge ap_clk);

        // Reset state
        check_value("request_valid", request_valid, 0);
        check_value("done", done, 0);
        check_value("config_ready", config_ready, 1);

        // Basic run, 17 requests
        cfg               = '0;
        cfg.array_pointer = 32'h1000_0000;
        cfg.index_start   = 16'd3;
        cfg.index_end     = 16'd20;
        cfg.stride        = 16'd1;
        cfg.shift_amount  = 5'd2;
        cfg.shift_left    = 1'b1;
        run_config(cfg, 500);
        check_value("basic count", received, 17);

        // Random strides with right shift
        repeat (6) begin
            cfg = random_config();
            run_config(cfg, 1000);
        end

        // Back-pressure: long stall, then random ready
        cfg               = '0;
        cfg.array_pointer = $urandom;
        cfg.index_start   = 16'd0;
        cfg.index_end     = 16'd40;
        cfg.stride        = 16'd1;
        cfg.shift_amount  = 5'd3;
        cfg.shift_left    = 1'b1;
        set_ready_mode(60, 1'b1);
        run_config(cfg, 3000);
        check_value("back-pressure count", received, 40);
        set_ready_mode(0, 1'b0);

        // Empty ranges
        cfg.index_start = 16'd30;
        cfg.index_end   = 16'd30;
        run_config(cfg, 200);
        check_value("empty count", received, 0);
        cfg.index_start = 16'd50;
        cfg.index_end   = 16'd10;
        run_config(cfg, 200);
        check_value("empty count", received, 0);

        // New run started from DONE
        cfg.array_pointer = 32'hCAFE_0040;
        cfg.index_start   = 16'd100;
        cfg.index_end     = 16'd130;
        cfg.stride        = 16'd3;
        cfg.shift_amount  = 5'd1;
        cfg.shift_left    = 1'b1;
        run_config(cfg, 500);
        check_value("reconfig count", received, 10);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule : tb_merge_data_generator

`default_nettype wire

// ==== src/merge_data_generator.sv ====
// Top level of the index request generator: FSM, counter, builder and request FIFO
`timescale 1ns/1ns
`default_nettype none

module merge_data_generator
    import merge_gen_pkg::*;
#(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic         ap_clk,
    input  logic         areset_generator,
    input  logic         config_valid,
    output logic         config_ready,
    input  gen_config_t  gen_config,
    output logic         request_valid,
    input  logic         request_ready,
    output mem_request_t request,
    output logic         done
);

    gen_config_t  held_config;
    index_t       count;
    fifo_status_t fifo_status;
    logic         counter_load;
    logic         counter_enable;
    logic         build_valid;
    logic         push_valid;
    mem_request_t push_request;

    // ------------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------------
    generator_fsm #(
        .PROG_THRESH (PROG_THRESH)
    ) u_generator_fsm (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .config_valid     (config_valid),
        .config_ready     (config_ready),
        .gen_config       (gen_config),
        .held_config      (held_config),
        .count            (count),
        .fifo_status      (fifo_status),
        .counter_load     (counter_load),
        .counter_enable   (counter_enable),
        .build_valid      (build_valid),
        .done             (done)
    );

    index_counter u_index_counter (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .load             (counter_load),
        .enable           (counter_enable),
        .index_start      (held_config.index_start),
        .stride           (held_config.stride),
        .count            (count)
    );

    // ------------------------------------------------------------------------
    // Request path
    // ------------------------------------------------------------------------
    request_builder u_request_builder (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .build_valid      (build_valid),
        .count            (count),
        .held_config      (held_config),
        .push_valid       (push_valid),
        .push_request     (push_request)
    );

    request_fifo #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .PROG_THRESH (PROG_THRESH)
    ) u_request_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push_valid       (push_valid),
        .push_request     (push_request),
        .request_valid    (request_valid),
        .request_ready    (request_ready),
        .request          (request),
        .fifo_status      (fifo_status)
    );

endmodule : merge_data_generator

`default_nettype wire

// ==== src/request_fifo.sv ====
// Synchronous request FIFO with programmable-full flag and valid/ready read port
`timescale 1ns/1ns
`default_nettype none

module request_fifo
    import merge_gen_pkg::*;
#(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic         ap_clk,
    input  logic         areset_generator,
    input  logic         push_valid,
    input  mem_request_t push_request,
    output logic         request_valid,
    input  logic         request_ready,
    output mem_request_t request,
    output fifo_status_t fifo_status
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    mem_request_t     mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] occupancy;
    logic             push;
    logic             pop;

    assign push = push_valid && !fifo_status.full;
    assign pop  = request_valid && request_ready;

    // ------------------------------------------------------------------------
    // Flags and read side
    // ------------------------------------------------------------------------
    assign fifo_status.full      = (occupancy == CNT_W'(FIFO_DEPTH));
    assign fifo_status.empty     = (occupancy == '0);
    assign fifo_status.prog_full = (occupancy >= CNT_W'(PROG_THRESH));

    // Head entry stays put until it is taken
    assign request_valid = !fifo_status.empty;
    assign request       = mem[rd_ptr];

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_request;
        end
    end

    // Pointers wrap naturally for a power-of-two depth
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    // Builder must have been throttled before the FIFO filled up
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        push_valid |-> !fifo_status.full);

endmodule : request_fifo

`default_nettype wire

// ==== generator/request_builder.sv ====
// Registered stage that turns the current index into a memory request
`timescale 1ns/1ns
`default_nettype none

module request_builder
    import merge_gen_pkg::*;
(
    input  logic         ap_clk,
    input  logic         areset_generator,
    input  logic         build_valid,
    input  index_t       count,
    input  gen_config_t  held_config,
    output logic         push_valid,
    output mem_request_t push_request
);

    logic [ADDR_W-1:0] index_ext;
    logic [ADDR_W-1:0] offset_next;

    // Index widened to address width before the shift
    assign index_ext = {{(ADDR_W-INDEX_W){1'b0}}, count};

    always_comb begin
        if (held_config.shift_left) begin
            offset_next = index_ext << held_config.shift_amount;
        end else begin
            offset_next = index_ext >> held_config.shift_amount;
        end
    end

    // ------------------------------------------------------------------------
    // Output stage
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            push_valid <= 1'b0;
        end else begin
            push_valid <= build_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (build_valid) begin
            push_request.base   <= held_config.array_pointer;
            push_request.offset <= offset_next;
            push_request.data   <= count;
        end
    end

endmodule : request_builder

`default_nettype wire

// ==== generator/index_counter.sv ====
// Loadable vertex index counter stepping by a stride
`timescale 1ns/1ns
`default_nettype none

module index_counter
    import merge_gen_pkg::*;
(
    input  logic   ap_clk,
    input  logic   areset_generator,
    input  logic   load,
    input  logic   enable,
    input  index_t index_start,
    input  index_t stride,
    output index_t count
);

    index_t count_next;

    // Load wins over a step
    always_comb begin
        count_next = count;
        if (load) begin
            count_next = index_start;
        end else if (enable) begin
            count_next = count + stride;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            count <= '0;
        end else begin
            count <= count_next;
        end
    end

endmodule : index_counter

`default_nettype wire

// ==== generator/generator_fsm.sv ====
// Generator FSM with configuration register, end-of-range test, pause and drain control
`timescale 1ns/1ns
`default_nettype none

module generator_fsm
    import merge_gen_pkg::*;
#(
    parameter int PROG_THRESH = 8
) (
    input  logic         ap_clk,
    input  logic         areset_generator,
    input  logic         config_valid,
    output logic         config_ready,
    input  gen_config_t  gen_config,
    output gen_config_t  held_config,
    input  index_t       count,
    input  fifo_status_t fifo_status,
    output logic         counter_load,
    output logic         counter_enable,
    output logic         build_valid,
    output logic         done
);

    gen_state_t state;
    gen_state_t next_state;
    logic       accept;
    logic       in_range;
    // Build pulses of the last two cycles that may still be on their way to the FIFO
    logic [1:0] build_hist;

    assign config_ready = (state == IDLE) || (state == DONE);
    assign accept       = config_valid && config_ready;

    // The only end-of-range comparison in the design
    assign in_range = count < held_config.index_end;

    assign counter_load   = (state == START);
    assign build_valid    = (state == BUSY) && in_range && !fifo_status.prog_full;
    assign counter_enable = build_valid;
    assign done           = (state == DONE);

    // ------------------------------------------------------------------------
    // Configuration register
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (accept) begin
            held_config <= gen_config;
        end
    end

    // ------------------------------------------------------------------------
    // State register and build history
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state      <= IDLE;
            build_hist <= 2'b00;
        end else begin
            state      <= next_state;
            build_hist <= {build_hist[0], build_valid};
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE, DONE: begin
                if (accept) begin
                    next_state = START;
                end
            end
            START: begin
                next_state = BUSY;
            end
            BUSY: begin
                if (!in_range) begin
                    next_state = DRAIN;
                end else if (fifo_status.prog_full) begin
                    next_state = PAUSE;
                end
            end
            PAUSE: begin
                if (!fifo_status.prog_full) begin
                    next_state = BUSY;
                end
            end
            DRAIN: begin
                // Builder stage and FIFO both empty
                if (build_hist == 2'b00 && fifo_status.empty) begin
                    next_state = DONE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Assertions
    // ------------------------------------------------------------------------
    // Configuration register only loads between runs
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        !(state == IDLE || state == DONE) |=> $stable(held_config));

    // Counter stands still during a pause and the FIFO never runs dry in it
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        (state == PAUSE) |-> (PROG_THRESH < 2 || !fifo_status.empty) ##1 $stable(count));

endmodule : generator_fsm

`default_nettype wire

// ==== common/merge_gen_pkg.sv ====
// Shared widths, configuration and request words, FIFO status and generator states
`default_nettype none

package merge_gen_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    localparam int INDEX_W = 16;
    localparam int ADDR_W  = 32;
    localparam int SHIFT_W = 5;

    // Spare bits that round the configuration word up
    localparam int CONFIG_PAD_W = 17;

    typedef logic [INDEX_W-1:0] index_t;

    // ------------------------------------------------------------------------
    // Configuration word, 103 bits
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [ADDR_W-1:0]       array_pointer;
        index_t                  index_start;
        index_t                  index_end;
        index_t                  stride;
        logic [SHIFT_W-1:0]      shift_amount;
        // High selects a left shift of the index
        logic                    shift_left;
        logic [CONFIG_PAD_W-1:0] reserved;
    } gen_config_t;

    // Memory request toward the consumer
    typedef struct packed {
        logic [ADDR_W-1:0] base;
        logic [ADDR_W-1:0] offset;
        index_t            data;
    } mem_request_t;

    // Flags reported by the request FIFO
    typedef struct packed {
        logic full;
        logic empty;
        logic prog_full;
    } fifo_status_t;

    // Generator FSM states
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        START = 3'd1,
        BUSY  = 3'd2,
        PAUSE = 3'd3,
        DRAIN = 3'd4,
        DONE  = 3'd5
    } gen_state_t;

endpackage : merge_gen_pkg

`default_nettype wire
